//--- Makefile
TOP = mips_exec_core_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f mips_exec_core.f \
		--top-module $(TOP) -o sim

run: build
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

lint:
	verilator --lint-only -Wall --timing -f mips_exec_core.f --top-module mips_exec_core

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

//--- include/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

`define MIPS_DATA_W    32
`define MIPS_REG_W     5
`define MIPS_NUM_REGS  32

// primary opcodes
`define MIPS_OP_RTYPE  6'h00
`define MIPS_OP_ADDI   6'h08
`define MIPS_OP_SLTI   6'h0a
`define MIPS_OP_ANDI   6'h0c
`define MIPS_OP_ORI    6'h0d
`define MIPS_OP_LUI    6'h0f

// R-type funct field
`define MIPS_FN_ADD    6'h20
`define MIPS_FN_SUB    6'h22
`define MIPS_FN_AND    6'h24
`define MIPS_FN_OR     6'h25
`define MIPS_FN_SLT    6'h2a

`endif

//--- mips_exec_core.f
+incdir+include
verilog/mips_pkg.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/pipe_reg.sv
verilog/execute_stage.sv
verilog/mips_exec_core.sv
test/mips_exec_core_asserts.sv
test/mips_exec_core_tb.sv

//--- test/mips_exec_core_asserts.sv
`timescale 1ns/1ps

`include "mips_config.svh"

module mips_exec_core_asserts (
    input logic                   i_clock,
    input logic                   reset,
    input mips_pkg::id_ex_t       id_ex_q,
    input mips_pkg::ex_wb_t       ex_wb_q,
    input logic                   wb_valid,
    input logic [`MIPS_REG_W-1:0] wb_dest
);

    // first cycle out of reset is empty
    wb_clear_after_reset: assert property (
        @(posedge i_clock) reset |=> !wb_valid
    ) else $error("wb_valid set in the cycle after reset");

    // id/ex valid becomes ex/wb valid when the instruction writes
    valid_flow: assert property (
        @(posedge i_clock) disable iff (reset)
        id_ex_q.valid |=> (ex_wb_q.valid == $past(id_ex_q.ctrl.reg_write))
    ) else $error("ex/wb valid does not follow id/ex reg_write");

    no_r0_writeback: assert property (
        @(posedge i_clock) disable iff (reset)
        wb_valid |-> (wb_dest != '0)
    ) else $error("writeback to register zero");

endmodule

bind mips_exec_core mips_exec_core_asserts mips_exec_core_asserts_inst (
    .i_clock  (i_clock),
    .reset    (reset),
    .id_ex_q  (id_ex_q),
    .ex_wb_q  (ex_wb_q),
    .wb_valid (wb_valid),
    .wb_dest  (wb_dest)
);

//--- test/mips_exec_core_tb.sv
`timescale 1ns/1ps

`include "mips_config.svh"

module mips_exec_core_tb;

    localparam int stream_len = 200;
    localparam int max_gap    = 3;
    localparam int r_rounds   = 12;
    // cycle budget of all tests together
    localparam int run_cycles = 60 + r_rounds * 12 + 80 + 40 + stream_len * (max_gap + 1);
    localparam int margin     = 100;

    typedef struct packed {
        logic [31:0]             tag;
        logic                    valid;
        logic [`MIPS_REG_W-1:0]  dest;
        logic [`MIPS_DATA_W-1:0] data;
    } wb_exp_t;

    logic                    i_clock;
    logic                    reset;
    logic [`MIPS_DATA_W-1:0] instr;
    logic                    instr_valid;
    logic                    wb_valid;
    logic [`MIPS_REG_W-1:0]  wb_dest;
    logic [`MIPS_DATA_W-1:0] wb_data;

    logic [`MIPS_DATA_W-1:0] ref_regs [`MIPS_NUM_REGS];
    wb_exp_t                 exp_q [$];
    wb_exp_t                 head;
    logic [31:0]             cycle;
    logic                    checking;
    int                      errors;
    int                      checks;
    integer                  seed;

    mips_exec_core mips_exec_core_inst (
        .i_clock     (i_clock),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .wb_valid    (wb_valid),
        .wb_dest     (wb_dest),
        .wb_data     (wb_data)
    );

    initial begin
        i_clock = 1'b0;
        forever #5 i_clock = ~i_clock;
    end

    always @(posedge i_clock) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] rtype_word(input logic [5:0] funct, input logic [4:0] rd,
                                               input logic [4:0] rs, input logic [4:0] rt);
        return {`MIPS_OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rt,
                                               input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // architectural result of one instruction against the reference registers
    function automatic wb_exp_t predict(input logic [31:0] word);
        wb_exp_t     e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        logic [31:0] zx;
        logic [31:0] r;
        logic [4:0]  d;
        logic        ok;
        a  = ref_regs[word[25:21]];
        b  = ref_regs[word[20:16]];
        sx = {{16{word[15]}}, word[15:0]};
        zx = {16'h0000, word[15:0]};
        d  = word[20:16];
        r  = 32'd0;
        ok = 1'b1;
        case (word[31:26])
            `MIPS_OP_RTYPE: begin
                d = word[15:11];
                case (word[5:0])
                    `MIPS_FN_ADD: r = a + b;
                    `MIPS_FN_SUB: r = a - b;
                    `MIPS_FN_AND: r = a & b;
                    `MIPS_FN_OR:  r = a | b;
                    `MIPS_FN_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:      ok = 1'b0;
                endcase
            end
            `MIPS_OP_ADDI: r = a + sx;
            `MIPS_OP_SLTI: r = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
            `MIPS_OP_ANDI: r = a & zx;
            `MIPS_OP_ORI:  r = a | zx;
            `MIPS_OP_LUI:  r = {word[15:0], 16'h0000};
            default:       ok = 1'b0;
        endcase
        e.tag   = 32'd0;
        e.valid = ok && (d != 5'd0);
        e.dest  = d;
        e.data  = r;
        return e;
    endfunction

    // called on a falling edge, returns on the next one
    task automatic issue(input logic [31:0] word);
        wb_exp_t e;
        e     = predict(word);
        e.tag = cycle;
        exp_q.push_back(e);
        if (e.valid) begin
            ref_regs[e.dest] = e.data;
        end
        instr       = word;
        instr_valid = 1'b1;
        @(negedge i_clock);
        instr_valid = 1'b0;
    endtask

    // junk on the bus while the strobe is low
    task automatic idle(input int n);
        repeat (n) begin
            instr       = $random(seed);
            instr_valid = 1'b0;
            @(negedge i_clock);
        end
    endtask

    task automatic drain;
        while (exp_q.size() != 0) begin
            idle(1);
        end
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        issue(itype_word(`MIPS_OP_LUI, rd, 5'd0, value[31:16]));
        issue(itype_word(`MIPS_OP_ORI, rd, rd, value[15:0]));
    endtask

    task automatic check_wb(input wb_exp_t e);
        checks++;
        if (e.valid) begin
            assert (wb_valid === 1'b1) else begin
                errors++;
                $display("missing writeback for r%0d at %0t", e.dest, $time);
            end
            if (wb_valid === 1'b1) begin
                assert (wb_dest === e.dest) else begin
                    errors++;
                    $display("mismatch at %0t: wb_dest %0d, expected %0d",
                             $time, wb_dest, e.dest);
                end
                assert (wb_data === e.data) else begin
                    errors++;
                    $display("mismatch at %0t: r%0d data %h, expected %h",
                             $time, e.dest, wb_data, e.data);
                end
            end
        end else begin
            assert (wb_valid === 1'b0) else begin
                errors++;
                $display("unexpected writeback to r%0d at %0t from a non-writing instruction",
                         wb_dest, $time);
            end
        end
    endtask

    // writeback is due exactly two cycles after issue
    always @(negedge i_clock) begin
        if (checking) begin
            if (exp_q.size() != 0 && exp_q[0].tag == cycle - 2) begin
                head = exp_q.pop_front();
                check_wb(head);
            end else begin
                checks++;
                assert (wb_valid === 1'b0) else begin
                    errors++;
                    $display("unexpected writeback to r%0d at %0t with no instruction due",
                             wb_dest, $time);
                end
            end
        end
    end

    task automatic immediates_after_reset;
        idle(5);
        issue(itype_word(`MIPS_OP_ORI, 5'd1, 5'd0, 16'hbeef));
        issue(itype_word(`MIPS_OP_ADDI, 5'd2, 5'd0, 16'hfff0));
        issue(itype_word(`MIPS_OP_ADDI, 5'd3, 5'd0, 16'h8000));
        issue(itype_word(`MIPS_OP_LUI, 5'd4, 5'd0, 16'h1234));
        issue(itype_word(`MIPS_OP_ORI, 5'd4, 5'd4, 16'h8765));
        issue(itype_word(`MIPS_OP_ADDI, 5'd5, 5'd1, 16'hffff));
        issue(itype_word(`MIPS_OP_ANDI, 5'd6, 5'd2, 16'hf0f0));
        issue(itype_word(`MIPS_OP_SLTI, 5'd7, 5'd2, 16'hfff1));
        issue(itype_word(`MIPS_OP_SLTI, 5'd8, 5'd1, 16'h8000));
        drain;
    endtask

    task automatic rtype_random_operands;
        logic [31:0] a;
        logic [31:0] b;
        for (int n = 0; n < r_rounds; n++) begin
            a = $random(seed);
            b = $random(seed);
            // a few fixed corners for the signed compare
            case (n)
                0: begin
                    a = 32'hfffffffb;
                    b = 32'hfffffffd;
                end
                1: b = a;
                2: begin
                    a = 32'h80000000;
                    b = 32'h7fffffff;
                end
                default: ;
            endcase
            load_const(5'd1, a);
            load_const(5'd2, b);
            issue(rtype_word(`MIPS_FN_ADD, 5'd3, 5'd1, 5'd2));
            issue(rtype_word(`MIPS_FN_SUB, 5'd4, 5'd1, 5'd2));
            issue(rtype_word(`MIPS_FN_AND, 5'd5, 5'd1, 5'd2));
            issue(rtype_word(`MIPS_FN_OR, 5'd6, 5'd1, 5'd2));
            issue(rtype_word(`MIPS_FN_SLT, 5'd7, 5'd1, 5'd2));
            issue(rtype_word(`MIPS_FN_SLT, 5'd8, 5'd2, 5'd1));
        end
        drain;
    endtask

    task automatic dependent_chains;
        logic [31:0] rnd;
        for (int n = 0; n < 4; n++) begin
            rnd = $random(seed);
            load_const(5'd1, rnd);
            rnd = $random(seed);
            load_const(5'd2, rnd);
            issue(rtype_word(`MIPS_FN_ADD, 5'd3, 5'd1, 5'd2));
            // both operands one back
            issue(rtype_word(`MIPS_FN_ADD, 5'd4, 5'd3, 5'd3));
            issue(rtype_word(`MIPS_FN_SUB, 5'd5, 5'd4, 5'd3));
            issue(rtype_word(`MIPS_FN_OR, 5'd6, 5'd4, 5'd5));
            issue(rtype_word(`MIPS_FN_AND, 5'd7, 5'd6, 5'd5));
            issue(rtype_word(`MIPS_FN_SLT, 5'd8, 5'd6, 5'd7));
            issue(itype_word(`MIPS_OP_ADDI, 5'd9, 5'd8, rnd[15:0]));
            issue(rtype_word(`MIPS_FN_SUB, 5'd10, 5'd7, 5'd9));
        end
        issue(itype_word(`MIPS_OP_ORI, 5'd11, 5'd0, 16'h0001));
        repeat (6) begin
            issue(itype_word(`MIPS_OP_ADDI, 5'd11, 5'd11, 16'hffff));
        end
        issue(rtype_word(`MIPS_FN_ADD, 5'd12, 5'd11, 5'd11));
        drain;
    endtask

    task automatic zero_and_illegal;
        load_const(5'd1, 32'h13579bdf);
        issue(itype_word(`MIPS_OP_ORI, 5'd0, 5'd0, 16'h1234));
        issue(rtype_word(`MIPS_FN_ADD, 5'd11, 5'd0, 5'd0));
        issue(rtype_word(`MIPS_FN_ADD, 5'd0, 5'd1, 5'd1));
        issue(rtype_word(`MIPS_FN_OR, 5'd12, 5'd0, 5'd1));
        issue(itype_word(`MIPS_OP_ADDI, 5'd0, 5'd1, 16'h0005));
        idle(1);
        issue(itype_word(`MIPS_OP_ADDI, 5'd13, 5'd0, 16'h0000));
        issue({6'h3f, 5'd1, 5'd14, 16'h1111});
        // sll, nor and lw are all outside the set
        issue(rtype_word(6'h00, 5'd15, 5'd1, 5'd1));
        issue(rtype_word(6'h27, 5'd16, 5'd1, 5'd1));
        issue(itype_word(6'h23, 5'd17, 5'd1, 16'h0000));
        idle(4);
        issue(rtype_word(`MIPS_FN_OR, 5'd18, 5'd14, 5'd15));
        drain;
    endtask

    // small register range keeps dependencies frequent
    function automatic logic [31:0] make_word(input logic [3:0] kind, input logic [31:0] bits);
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        rs = {2'b00, bits[2:0]};
        rt = {2'b00, bits[5:3]};
        rd = {2'b00, bits[8:6]};
        case (kind)
            4'd0:    return rtype_word(`MIPS_FN_ADD, rd, rs, rt);
            4'd1:    return rtype_word(`MIPS_FN_SUB, rd, rs, rt);
            4'd2:    return rtype_word(`MIPS_FN_AND, rd, rs, rt);
            4'd3:    return rtype_word(`MIPS_FN_OR, rd, rs, rt);
            4'd4:    return rtype_word(`MIPS_FN_SLT, rd, rs, rt);
            4'd5:    return itype_word(`MIPS_OP_ADDI, rt, rs, bits[31:16]);
            4'd6:    return itype_word(`MIPS_OP_SLTI, rt, rs, bits[31:16]);
            4'd7:    return itype_word(`MIPS_OP_ANDI, rt, rs, bits[31:16]);
            4'd8:    return itype_word(`MIPS_OP_ORI, rt, rs, bits[31:16]);
            4'd9:    return itype_word(`MIPS_OP_LUI, rt, 5'd0, bits[31:16]);
            4'd10:   return bits;
            4'd11:   return rtype_word(6'h21, rd, rs, rt);
            4'd12:   return itype_word(`MIPS_OP_ADDI, rt, rs, bits[31:16]);
            4'd13:   return rtype_word(`MIPS_FN_ADD, rd, rs, rt);
            4'd14:   return rtype_word(`MIPS_FN_SUB, rd, rs, rt);
            default: return itype_word(`MIPS_OP_ORI, rt, rs, bits[31:16]);
        endcase
    endfunction

    task automatic mixed_stream;
        logic [31:0] rnd;
        logic [31:0] bits;
        int          gap;
        for (int n = 0; n < stream_len; n++) begin
            rnd  = $random(seed);
            bits = $random(seed);
            issue(make_word(rnd[3:0], bits));
            gap = (rnd[7:6] == 2'b00) ? int'(rnd[5:4]) : 0;
            idle(gap);
        end
        drain;
    endtask

    initial begin
        reset       = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        checking    = 1'b0;
        cycle       = 32'd0;
        errors      = 0;
        checks      = 0;
        seed        = 32'h439798e0;
        for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
            ref_regs[i] = '0;
        end
        repeat (2) @(posedge i_clock);
        @(negedge i_clock);
        reset    = 1'b0;
        checking = 1'b1;

        immediates_after_reset();
        rtype_random_operands();
        dependent_chains();
        zero_and_illegal();
        mixed_stream();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #((run_cycles + margin) * 10);
        $display("watchdog expired after %0d cycles, the run did not finish",
                 run_cycles + margin);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- verilog/execute_stage.sv
`timescale 1ns/1ps

`include "mips_config.svh"

module execute_stage (
    input  mips_pkg::id_ex_t id_ex,
    input  mips_pkg::ex_wb_t ex_wb,
    output mips_pkg::ex_wb_t result
);
    import mips_pkg::*;

    logic                    fwd_ok;
    logic                    fwd_a;
    logic                    fwd_b;
    logic [`MIPS_DATA_W-1:0] op_a;
    logic [`MIPS_DATA_W-1:0] rt_val;
    logic [`MIPS_DATA_W-1:0] op_b;
    logic [`MIPS_DATA_W-1:0] alu_out;
    logic                    lt;

    // the instruction one ahead sits in ex/wb
    assign fwd_ok = ex_wb.valid && (ex_wb.dest != '0);
    assign fwd_a  = fwd_ok && (ex_wb.dest == id_ex.rs);
    assign fwd_b  = fwd_ok && (ex_wb.dest == id_ex.rt);

    assign op_a   = fwd_a ? ex_wb.result : id_ex.data_a;
    assign rt_val = fwd_b ? ex_wb.result : id_ex.data_b;

    // immediate replaces rt for i-type
    assign op_b   = id_ex.ctrl.alu_src ? id_ex.immediate : rt_val;

    // signed compare
    assign lt     = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_ADD: alu_out = op_a + op_b;
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_SLT: alu_out = {{(`MIPS_DATA_W-1){1'b0}}, lt};
            // upper half already placed by the decoder
            ALU_LUI: alu_out = id_ex.immediate;
            default: alu_out = '0;
        endcase
    end

    assign result = '{
        valid:  id_ex.valid && id_ex.ctrl.reg_write,
        dest:   id_ex.dest,
        result: alu_out
    };

endmodule

//--- verilog/instr_decoder.sv
`timescale 1ns/1ps

`include "mips_config.svh"

module instr_decoder (
    input  logic [`MIPS_DATA_W-1:0] instr,
    input  logic                    instr_valid,
    output mips_pkg::id_ex_t        dec,
    output logic [`MIPS_REG_W-1:0]  rs,
    output logic [`MIPS_REG_W-1:0]  rt
);
    import mips_pkg::*;

    logic [5:0]             opcode;
    logic [5:0]             funct;
    logic [`MIPS_REG_W-1:0] rd;
    logic [15:0]            imm16;
    logic [`MIPS_REG_W-1:0] dest;
    logic                   legal;

    // instruction fields
    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign funct  = instr[5:0];
    assign imm16  = instr[15:0];

    always_comb begin
        dec   = '0;
        legal = 1'b1;
        // i-type writes rt
        dest  = rt;
        case (opcode)
            `MIPS_OP_RTYPE: begin
                dest = rd;
                case (funct)
                    `MIPS_FN_ADD: dec.ctrl.alu_op = ALU_ADD;
                    `MIPS_FN_SUB: dec.ctrl.alu_op = ALU_SUB;
                    `MIPS_FN_AND: dec.ctrl.alu_op = ALU_AND;
                    `MIPS_FN_OR:  dec.ctrl.alu_op = ALU_OR;
                    `MIPS_FN_SLT: dec.ctrl.alu_op = ALU_SLT;
                    default:      legal = 1'b0;
                endcase
            end
            `MIPS_OP_ADDI, `MIPS_OP_SLTI: begin
                dec.ctrl.alu_src = 1'b1;
                dec.ctrl.alu_op  = (opcode == `MIPS_OP_ADDI) ? ALU_ADD : ALU_SLT;
                dec.immediate    = {{(`MIPS_DATA_W-16){imm16[15]}}, imm16};
            end
            `MIPS_OP_ANDI, `MIPS_OP_ORI: begin
                dec.ctrl.alu_src = 1'b1;
                dec.ctrl.alu_op  = (opcode == `MIPS_OP_ANDI) ? ALU_AND : ALU_OR;
                dec.immediate    = {{(`MIPS_DATA_W-16){1'b0}}, imm16};
            end
            `MIPS_OP_LUI: begin
                dec.ctrl.alu_src = 1'b1;
                dec.ctrl.alu_op  = ALU_LUI;
                dec.immediate    = {imm16, {(`MIPS_DATA_W-16){1'b0}}};
            end
            default: legal = 1'b0;
        endcase

        // idle, illegal and r0 destination all become bubbles
        dec.valid          = instr_valid && legal && (dest != '0);
        dec.ctrl.reg_write = dec.valid;
        dec.rs             = rs;
        dec.rt             = rt;
        dec.dest           = dest;
    end

endmodule

//--- verilog/mips_exec_core.sv
`timescale 1ns/1ps

`include "mips_config.svh"

module mips_exec_core (
    input  logic                    i_clock,
    input  logic                    reset,
    input  logic [`MIPS_DATA_W-1:0] instr,
    input  logic                    instr_valid,
    output logic                    wb_valid,
    output logic [`MIPS_REG_W-1:0]  wb_dest,
    output logic [`MIPS_DATA_W-1:0] wb_data
);
    import mips_pkg::*;

    id_ex_t                  dec;
    id_ex_t                  id_ex_d;
    id_ex_t                  id_ex_q;
    ex_wb_t                  ex_wb_d;
    ex_wb_t                  ex_wb_q;
    logic [`MIPS_REG_W-1:0]  rs;
    logic [`MIPS_REG_W-1:0]  rt;
    logic [`MIPS_DATA_W-1:0] rs_data;
    logic [`MIPS_DATA_W-1:0] rt_data;

    instr_decoder instr_decoder_inst (
        .instr       (instr),
        .instr_valid (instr_valid),
        .dec         (dec),
        .rs          (rs),
        .rt          (rt)
    );

    reg_file reg_file_inst (
        .i_clock (i_clock),
        .reset   (reset),
        .rs_addr (rs),
        .rt_addr (rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb      (ex_wb_q)
    );

    // decode record plus register operands
    assign id_ex_d = '{
        valid:     dec.valid,
        ctrl:      dec.ctrl,
        rs:        dec.rs,
        rt:        dec.rt,
        dest:      dec.dest,
        data_a:    rs_data,
        data_b:    rt_data,
        immediate: dec.immediate
    };

    pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .i_clock (i_clock),
        .reset   (reset),
        .d       (id_ex_d),
        .q       (id_ex_q)
    );

    execute_stage execute_stage_inst (
        .id_ex  (id_ex_q),
        .ex_wb  (ex_wb_q),
        .result (ex_wb_d)
    );

    pipe_reg #(.payload_t(ex_wb_t)) ex_wb_reg (
        .i_clock (i_clock),
        .reset   (reset),
        .d       (ex_wb_d),
        .q       (ex_wb_q)
    );

    assign wb_valid = ex_wb_q.valid;
    assign wb_dest  = ex_wb_q.dest;
    assign wb_data  = ex_wb_q.result;

endmodule

//--- verilog/mips_pkg.sv
`include "mips_config.svh"

package mips_pkg;

    // alu operations
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_LUI = 3'd5
    } alu_op_t;

    // control bits consumed in execute
    typedef struct packed {
        logic    reg_write;
        // immediate as operand b
        logic    alu_src;
        alu_op_t alu_op;
    } ex_ctrl_t;

    // decode to execute record
    typedef struct packed {
        logic                    valid;
        ex_ctrl_t                ctrl;
        // source numbers kept for forwarding
        logic [`MIPS_REG_W-1:0]  rs;
        logic [`MIPS_REG_W-1:0]  rt;
        // final destination with reg_dst already resolved
        logic [`MIPS_REG_W-1:0]  dest;
        logic [`MIPS_DATA_W-1:0] data_a;
        logic [`MIPS_DATA_W-1:0] data_b;
        // sign- or zero-extended already
        logic [`MIPS_DATA_W-1:0] immediate;
    } id_ex_t;

    // execute to writeback record that is valid only when it writes
    typedef struct packed {
        logic                    valid;
        logic [`MIPS_REG_W-1:0]  dest;
        logic [`MIPS_DATA_W-1:0] result;
    } ex_wb_t;

endpackage

//--- verilog/pipe_reg.sv
`timescale 1ns/1ps

// one stage boundary carrying a whole stage record
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     i_clock,
    input  logic     reset,
    input  payload_t d,
    output payload_t q
);

    // clearing the record drops its valid bit
    always_ff @(posedge i_clock) begin
        if (reset) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/1ps

`include "mips_config.svh"

module reg_file (
    input  logic                    i_clock,
    input  logic                    reset,
    input  logic [`MIPS_REG_W-1:0]  rs_addr,
    input  logic [`MIPS_REG_W-1:0]  rt_addr,
    output logic [`MIPS_DATA_W-1:0] rs_data,
    output logic [`MIPS_DATA_W-1:0] rt_data,
    input  mips_pkg::ex_wb_t        wb
);
    logic [`MIPS_DATA_W-1:0] regs [`MIPS_NUM_REGS];
    logic                    wr_en;

    // r0 never gets written
    assign wr_en = wb.valid && (wb.dest != '0);

    always_ff @(posedge i_clock) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.dest] <= wb.result;
        end
    end

    // write-through bypass lets the instruction two behind see the result
    assign rs_data = (rs_addr == '0)                  ? '0        :
                     (wr_en && (wb.dest == rs_addr))  ? wb.result :
                                                        regs[rs_addr];

    assign rt_data = (rt_addr == '0)                  ? '0        :
                     (wr_en && (wb.dest == rt_addr))  ? wb.result :
                                                        regs[rt_addr];

endmodule
